//--- src.f
src/div_pkg.sv
src/div_stream_fifo.sv
src/div_stage_pipe.sv
src/div_header_fsm.sv
src/div_kvs_drop.sv
src/div_pkt_counters.sv
src/div_top.sv
test/div_sva.sv
test/div_tb.sv

//--- Makefile
# Verilator flow for the memcached stream diverter

TOP := div_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- test/div_tb.sv
// Packets carry their id in data[255:224] of every beat; kvs_port and div_en change only when idle
`timescale 1ns/1ns
`default_nettype none

module div_tb import div_pkg::*; ();

	localparam int MAX_PKTS  = 64;
	localparam int MAX_BEATS = 8;
	// 25 packets, three drains and a 400 cycle stall, with wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        axis_aclk;
	logic        axis_resetn;
	axis_beat_t  s_axis;
	logic        s_axis_tvalid;
	logic        s_axis_tready;
	axis_beat_t  m_axis;
	logic        m_axis_tvalid;
	logic        m_axis_tready;
	axis_beat_t  kvs_m_axis;
	logic        kvs_m_axis_tvalid;
	logic        kvs_m_axis_tready;
	logic [15:0] kvs_port;
	logic        div_en;
	div_stats_t  stats;

	axis_beat_t pkt_beats [MAX_PKTS][MAX_BEATS];
	int         pkt_len [MAX_PKTS];
	route_e     pkt_route [MAX_PKTS];
	bit         pkt_burst [MAX_PKTS];
	int         rcv_cnt [2][MAX_PKTS];
	int         beat_idx [2];
	int         last_id [2];
	int         rcv_total [2];
	int         num_sent;
	int         burst_n;
	int         errors;
	int         cycles;
	integer     seed;
	bit         tready_fell;

	div_top i_div_top (.*);

	initial begin
		axis_aclk = 1'b0;
		forever #50 axis_aclk = ~axis_aclk;
	end

	task automatic report(input string msg);
		errors++;
		$display("** Error %0t ns: %s", $time, msg);
	endtask

	// Route by the diversion rules, computed from the builder arguments
	function automatic route_e expect_route(input bit udp_ip, input bit to_port,
		input bit from_port, input logic [7:0] magic, input logic [7:0] op,
		input logic [15:0] resvd, input int totlen);
		if (udp_ip && to_port && div_en && !(magic == MAGIC_REQ && totlen >= 512)) begin
			if (magic == MAGIC_REQ && (op == OP_SET || op == OP_DELETE))
				return ROUTE_BOTH;
			return ROUTE_KVS;
		end
		if (udp_ip && from_port && div_en && magic == MAGIC_RES && op == OP_GET &&
			resvd == 16'h0 && totlen < 512)
			return ROUTE_BOTH;
		return ROUTE_NORMAL;
	endfunction

	task automatic send_pkt(input bit ip, input bit udp, input bit to_port,
		input bit from_port, input logic [7:0] magic, input logic [7:0] op,
		input logic [15:0] resvd, input int totlen, input int nbeats, input bit burst);
		axis_beat_t  b;
		int          id;
		logic [15:0] sp;
		logic [15:0] dp;
		logic [31:0] len;
		id  = num_sent;
		sp  = from_port ? kvs_port : 16'd5000;
		dp  = to_port ? kvs_port : 16'd6000;
		len = totlen;
		for (int i = 0; i < nbeats; i++) begin
			b.data = {$random(seed), $random(seed), $random(seed), $random(seed),
				$random(seed), $random(seed), $random(seed), $random(seed)};
			b.user = {$random(seed), $random(seed), $random(seed), $random(seed)};
			b.keep = '1;
			b.last = (i == nbeats - 1);
			b.data[255:224] = id;
			b.data[223:216] = i[7:0];
			if (i == 0) begin
				b.data[ETH_TYPE_POS +: 16] = ip ? ETH_TYPE_IPV4 : 16'h0608;
				b.data[IP_PROTO_POS +: 8]  = udp ? IP_PROTO_UDP : 8'h06;
			end
			if (i == 1) begin
				// Wire order is big endian
				b.data[SPORT_POS +: 16]       = {sp[7:0], sp[15:8]};
				b.data[DPORT_POS +: 16]       = {dp[7:0], dp[15:8]};
				b.data[MEMC_MAGIC_POS +: 8]   = magic;
				b.data[MEMC_OPCODE_POS +: 8]  = op;
				b.data[MEMC_RESRVD_POS +: 16] = resvd;
				b.data[MEMC_TOTLEN_POS +: 32] = {len[7:0], len[15:8], len[23:16], len[31:24]};
			end
			pkt_beats[id][i] = b;
		end
		pkt_len[id]   = nbeats;
		pkt_burst[id] = burst;
		pkt_route[id] = expect_route(ip && udp, to_port, from_port, magic, op, resvd, totlen);
		num_sent++;
		for (int i = 0; i < nbeats; i++) begin
			@(negedge axis_aclk);
			s_axis        = pkt_beats[id][i];
			s_axis_tvalid = 1'b1;
			while (!s_axis_tready) begin
				tready_fell = 1'b1;
				@(negedge axis_aclk);
			end
		end
		@(negedge axis_aclk);
		s_axis_tvalid = 1'b0;
	endtask

	task automatic check_beat(input int port, input axis_beat_t b);
		int id;
		int idx;
		id  = int'(b.data[255:224]);
		idx = beat_idx[port];
		if (id < 0 || id >= num_sent) begin
			report($sformatf("port %0d carried unknown packet id %0d", port, id));
			return;
		end
		if (idx == 0) begin
			assert (port == 0 ? (pkt_route[id] != ROUTE_KVS || pkt_burst[id])
				: pkt_route[id] != ROUTE_NORMAL)
				else report($sformatf("packet %0d on wrong output %0d", id, port));
			assert (id > last_id[port])
				else report($sformatf("packet %0d out of order on port %0d", id, port));
		end
		assert (idx < pkt_len[id] && b == pkt_beats[id][idx])
			else report($sformatf("packet %0d beat %0d differs on port %0d", id, idx, port));
		if (b.last) begin
			assert (idx + 1 == pkt_len[id])
				else report($sformatf("packet %0d ended after %0d beats", id, idx + 1));
			rcv_cnt[port][id]++;
			rcv_total[port]++;
			last_id[port]  = id;
			beat_idx[port] = 0;
		end else begin
			beat_idx[port] = idx + 1;
		end
	endtask

	always @(posedge axis_aclk) begin
		if (axis_resetn && m_axis_tvalid && m_axis_tready)
			check_beat(0, m_axis);
		if (axis_resetn && kvs_m_axis_tvalid && kvs_m_axis_tready)
			check_beat(1, kvs_m_axis);
	end

	always @(posedge axis_aclk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors: %0d", errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Idle once every packet is in and both outputs stay quiet
	task automatic drain();
		int idle;
		idle = 0;
		while (idle < 16) begin
			@(negedge axis_aclk);
			if (!m_axis_tvalid && !kvs_m_axis_tvalid && stats.pkt_in == num_sent)
				idle++;
			else
				idle = 0;
		end
	endtask

	task automatic final_checks();
		int fb;
		int kv;
		fb = 0;
		kv = 0;
		for (int id = 0; id < num_sent; id++) begin
			if (pkt_burst[id]) begin
				fb += rcv_cnt[0][id];
				kv += rcv_cnt[1][id];
				assert (rcv_cnt[0][id] + rcv_cnt[1][id] <= 1)
					else report($sformatf("burst packet %0d delivered twice", id));
			end else begin
				assert (rcv_cnt[0][id] == (pkt_route[id] != ROUTE_KVS ? 1 : 0) &&
					rcv_cnt[1][id] == (pkt_route[id] != ROUTE_NORMAL ? 1 : 0))
					else report($sformatf("packet %0d copies %0d/%0d for route %s", id,
						rcv_cnt[0][id], rcv_cnt[1][id], pkt_route[id].name()));
			end
		end
		assert (kv + fb + int'(stats.kvs_drop) == burst_n)
			else report($sformatf("burst kvs %0d + normal %0d + drop %0d != %0d",
				kv, fb, stats.kvs_drop, burst_n));
		assert (tready_fell) else report("s_axis_tready never fell under back-pressure");
		assert (stats.pkt_in == num_sent) else report("pkt_in count wrong");
		assert (stats.norm_out == rcv_total[0]) else report("norm_out count wrong");
		assert (stats.kvs_out == rcv_total[1]) else report("kvs_out count wrong");
	endtask

	initial begin
		seed              = 89839;
		errors            = 0;
		cycles            = 0;
		num_sent          = 0;
		burst_n           = 0;
		tready_fell       = 1'b0;
		beat_idx          = '{0, 0};
		last_id           = '{-1, -1};
		rcv_total         = '{0, 0};
		axis_resetn       = 1'b0;
		s_axis            = '0;
		s_axis_tvalid     = 1'b0;
		m_axis_tready     = 1'b1;
		kvs_m_axis_tready = 1'b1;
		kvs_port          = 16'd11211;
		div_en            = 1'b1;
		repeat (3) @(negedge axis_aclk);
		axis_resetn = 1'b1;
		// Plain traffic, KVS GET, write-through, responses, long request
		send_pkt(0, 1, 1, 0, MAGIC_REQ, OP_GET, 16'h0, 64, 3, 0);
		send_pkt(1, 0, 1, 0, MAGIC_REQ, OP_GET, 16'h0, 64, 4, 0);
		send_pkt(1, 1, 1, 0, MAGIC_REQ, OP_GET, 16'h0, 64, 3, 0);
		send_pkt(1, 1, 1, 0, MAGIC_REQ, OP_SET, 16'h0, 200, 5, 0);
		send_pkt(1, 1, 1, 0, MAGIC_REQ, OP_DELETE, 16'h0, 48, 2, 0);
		send_pkt(1, 1, 0, 1, MAGIC_RES, OP_GET, 16'h0, 100, 4, 0);
		send_pkt(1, 1, 0, 1, MAGIC_RES, OP_SET, 16'h0, 40, 2, 0);
		send_pkt(1, 1, 1, 0, MAGIC_REQ, OP_GET, 16'h0, 600, 6, 0);
		drain();
		div_en = 1'b0;
		send_pkt(1, 1, 1, 0, MAGIC_REQ, OP_GET, 16'h0, 64, 3, 0);
		drain();
		div_en = 1'b1;
		// GET burst against stalled outputs
		m_axis_tready     = 1'b0;
		kvs_m_axis_tready = 1'b0;
		fork
			begin
				for (int i = 0; i < 16; i++) begin
					send_pkt(1, 1, 1, 0, MAGIC_REQ, OP_GET, 16'h0, 96, 4, 1);
					burst_n++;
				end
			end
			begin
				repeat (400) @(negedge axis_aclk);
				m_axis_tready     = 1'b1;
				kvs_m_axis_tready = 1'b1;
			end
		join
		drain();
		final_checks();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/div_sva.sv
// Protocol checks bound into div_top; reach into the header FSM for its state
`timescale 1ns/1ns
`default_nettype none

module div_sva import div_pkg::*; (
	input logic       axis_aclk,
	input logic       axis_resetn,
	input axis_beat_t m_axis,
	input logic       m_axis_tvalid,
	input logic       m_axis_tready,
	input axis_beat_t kvs_m_axis,
	input logic       kvs_m_axis_tvalid,
	input logic       kvs_m_axis_tready,
	input div_state_e state,
	input logic       beat_out,
	input logic       beat_last
);

	logic after_last;

	// Packet boundary as seen by beats leaving stage 2
	always_ff @(posedge axis_aclk) begin
		if (!axis_resetn) begin
			after_last <= 1'b1;
		end else if (beat_out) begin
			after_last <= beat_last;
		end
	end

	// Output beats stay put until taken
	norm_hold: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis))
		else $error("m_axis beat changed or vanished before ready");

	kvs_hold: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
		kvs_m_axis_tvalid && !kvs_m_axis_tready |=> kvs_m_axis_tvalid && $stable(kvs_m_axis))
		else $error("kvs_m_axis beat changed or vanished before ready");

	// Header state only between packets
	pkt_state: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
		state == (after_last ? ST_HEADER : ST_PACKET))
		else $error("FSM state disagrees with the packet boundary leaving stage 2");

	reset_quiet: assert property (@(posedge axis_aclk)
		!axis_resetn |=> !m_axis_tvalid && !kvs_m_axis_tvalid)
		else $error("Output valid high during reset");

endmodule

bind div_top div_sva i_div_sva (
	.axis_aclk        (axis_aclk),
	.axis_resetn      (axis_resetn),
	.m_axis           (m_axis),
	.m_axis_tvalid    (m_axis_tvalid),
	.m_axis_tready    (m_axis_tready),
	.kvs_m_axis       (kvs_m_axis),
	.kvs_m_axis_tvalid(kvs_m_axis_tvalid),
	.kvs_m_axis_tready(kvs_m_axis_tready),
	.state            (i_header_fsm.state),
	.beat_out         (advance && !stage2_empty),
	.beat_last        (stage2.last)
);

`default_nettype wire

//--- src/div_top.sv
// Memcached stream diverter; kvs_port and div_en are static levels, expected stable during traffic
`timescale 1ns/1ns
`default_nettype none

module div_top import div_pkg::*; #(
	parameter int RECV_DEPTH_BITS      = 4,
	parameter int NORM_DEPTH_BITS      = 4,
	parameter int KVS_STAGE_DEPTH_BITS = 5,
	parameter int KVS_OUT_DEPTH_BITS   = 4
) (
	input  logic        axis_aclk,
	input  logic        axis_resetn,
	input  axis_beat_t  s_axis,
	input  logic        s_axis_tvalid,
	output logic        s_axis_tready,
	output axis_beat_t  m_axis,
	output logic        m_axis_tvalid,
	input  logic        m_axis_tready,
	output axis_beat_t  kvs_m_axis,
	output logic        kvs_m_axis_tvalid,
	input  logic        kvs_m_axis_tready,
	input  logic [15:0] kvs_port,
	input  logic        div_en,
	output div_stats_t  stats
);

	axis_beat_t recv_dout;
	logic       recv_rd;
	logic       recv_nearly_full;
	logic       recv_empty;

	axis_beat_t stage1;
	axis_beat_t stage2;
	logic       stage1_empty;
	logic       stage2_empty;
	logic       advance;

	logic       hold;
	logic       norm_wr;
	logic       kvs_wr;
	logic       norm_full;
	logic       norm_nearly_full;
	logic       norm_empty;

	axis_beat_t kstage_dout;
	logic       kstage_nearly_full;
	logic       kstage_empty;
	logic       kout_nearly_full;
	logic       kout_empty;
	logic       pass_wr;
	logic       drop_start;

	assign s_axis_tready = !recv_nearly_full;

	div_stream_fifo #(
		.DEPTH_BITS(RECV_DEPTH_BITS)
	) i_recv_fifo (
		.axis_aclk  (axis_aclk),
		.axis_resetn(axis_resetn),
		.din        (s_axis),
		.wr_en      (s_axis_tvalid && s_axis_tready),
		.rd_en      (recv_rd),
		.dout       (recv_dout),
		.full       (),
		.nearly_full(recv_nearly_full),
		.empty      (recv_empty)
	);

	// Stage 2 moves on once its beat is written or it holds nothing
	assign advance = !hold && (stage2_empty || norm_wr || kvs_wr);

	div_stage_pipe i_stage_pipe (
		.axis_aclk   (axis_aclk),
		.axis_resetn (axis_resetn),
		.in_beat     (recv_dout),
		.in_empty    (recv_empty),
		.advance     (advance),
		.rd_en       (recv_rd),
		.stage1      (stage1),
		.stage2      (stage2),
		.stage1_empty(stage1_empty),
		.stage2_empty(stage2_empty)
	);

	div_header_fsm i_header_fsm (
		.axis_aclk          (axis_aclk),
		.axis_resetn        (axis_resetn),
		.stage1             (stage1),
		.stage2             (stage2),
		.stage1_empty       (stage1_empty),
		.stage2_empty       (stage2_empty),
		.norm_full          (norm_full),
		.norm_nearly_full   (norm_nearly_full),
		.kvs_nearly_full    (kstage_nearly_full),
		.kvs_out_nearly_full(kout_nearly_full),
		.div_en             (div_en),
		.kvs_port           (kvs_port),
		.hold               (hold),
		.norm_wr            (norm_wr),
		.kvs_wr             (kvs_wr)
	);

	div_stream_fifo #(
		.DEPTH_BITS(NORM_DEPTH_BITS)
	) i_norm_fifo (
		.axis_aclk  (axis_aclk),
		.axis_resetn(axis_resetn),
		.din        (stage2),
		.wr_en      (norm_wr),
		.rd_en      (m_axis_tvalid && m_axis_tready),
		.dout       (m_axis),
		.full       (norm_full),
		.nearly_full(norm_nearly_full),
		.empty      (norm_empty)
	);

	assign m_axis_tvalid = !norm_empty;

	// Staging FIFO empties one beat per cycle into the drop gate
	div_stream_fifo #(
		.DEPTH_BITS(KVS_STAGE_DEPTH_BITS)
	) i_kvs_stage_fifo (
		.axis_aclk  (axis_aclk),
		.axis_resetn(axis_resetn),
		.din        (stage2),
		.wr_en      (kvs_wr),
		.rd_en      (!kstage_empty),
		.dout       (kstage_dout),
		.full       (),
		.nearly_full(kstage_nearly_full),
		.empty      (kstage_empty)
	);

	div_kvs_drop i_kvs_drop (
		.axis_aclk      (axis_aclk),
		.axis_resetn    (axis_resetn),
		.beat           (kstage_dout),
		.beat_valid     (!kstage_empty),
		.out_nearly_full(kout_nearly_full),
		.pass_wr        (pass_wr),
		.drop_start     (drop_start)
	);

	div_stream_fifo #(
		.DEPTH_BITS(KVS_OUT_DEPTH_BITS)
	) i_kvs_out_fifo (
		.axis_aclk  (axis_aclk),
		.axis_resetn(axis_resetn),
		.din        (kstage_dout),
		.wr_en      (pass_wr),
		.rd_en      (kvs_m_axis_tvalid && kvs_m_axis_tready),
		.dout       (kvs_m_axis),
		.full       (),
		.nearly_full(kout_nearly_full),
		.empty      (kout_empty)
	);

	assign kvs_m_axis_tvalid = !kout_empty;

	// Packet completions are last-beat handshakes
	div_pkt_counters i_pkt_counters (
		.axis_aclk  (axis_aclk),
		.axis_resetn(axis_resetn),
		.in_done    (s_axis_tvalid && s_axis_tready && s_axis.last),
		.norm_done  (m_axis_tvalid && m_axis_tready && m_axis.last),
		.kvs_done   (kvs_m_axis_tvalid && kvs_m_axis_tready && kvs_m_axis.last),
		.drop_start (drop_start),
		.stats      (stats)
	);

endmodule

`default_nettype wire

//--- src/div_pkt_counters.sv
// Free-running packet counters, wrap at 2^32
`timescale 1ns/1ns
`default_nettype none

module div_pkt_counters import div_pkg::*; (
	input  logic       axis_aclk,
	input  logic       axis_resetn,
	input  logic       in_done,
	input  logic       norm_done,
	input  logic       kvs_done,
	input  logic       drop_start,
	output div_stats_t stats
);

	always_ff @(posedge axis_aclk) begin
		if (!axis_resetn) begin
			stats <= '0;
		end else begin
			if (in_done) begin
				stats.pkt_in <= stats.pkt_in + 32'd1;
			end
			if (norm_done) begin
				stats.norm_out <= stats.norm_out + 32'd1;
			end
			if (kvs_done) begin
				stats.kvs_out <= stats.kvs_out + 32'd1;
			end
			// One pulse per dropped packet
			if (drop_start) begin
				stats.kvs_drop <= stats.kvs_drop + 32'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/div_kvs_drop.sv
// Drops whole KVS packets whose first beat finds the output FIFO nearly full
`timescale 1ns/1ns
`default_nettype none

module div_kvs_drop import div_pkg::*; (
	input  logic       axis_aclk,
	input  logic       axis_resetn,
	input  axis_beat_t beat,
	input  logic       beat_valid,
	input  logic       out_nearly_full,
	output logic       pass_wr,
	output logic       drop_start
);

	logic first_q;
	logic drop_q;

	// Decision made on the first beat only
	assign drop_start = beat_valid && first_q && out_nearly_full;
	assign pass_wr    = beat_valid && !drop_start && !drop_q;

	always_ff @(posedge axis_aclk) begin
		if (!axis_resetn) begin
			first_q <= 1'b1;
			drop_q  <= 1'b0;
		end else if (beat_valid) begin
			first_q <= beat.last;
			if (beat.last) begin
				drop_q <= 1'b0;
			end else if (drop_start) begin
				drop_q <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/div_header_fsm.sv
// Classifies on the header beat plus the next beat; packets must be at least two beats long
`timescale 1ns/1ns
`default_nettype none

module div_header_fsm import div_pkg::*; (
	input  logic        axis_aclk,
	input  logic        axis_resetn,
	input  axis_beat_t  stage1,
	input  axis_beat_t  stage2,
	input  logic        stage1_empty,
	input  logic        stage2_empty,
	input  logic        norm_full,
	input  logic        norm_nearly_full,
	input  logic        kvs_nearly_full,
	input  logic        kvs_out_nearly_full,
	input  logic        div_en,
	input  logic [15:0] kvs_port,
	output logic        hold,
	output logic        norm_wr,
	output logic        kvs_wr
);

	div_state_e   state;
	route_e       route;
	route_e       hdr_route;
	route_e       cur_route;
	logic         is_udp;
	logic [15:0]  sport;
	logic [15:0]  dport;
	logic [7:0]   magic;
	memc_opcode_e opcode;
	logic [15:0]  resvd;
	logic [31:0]  totlen;
	logic         short_len;
	logic         norm_room;
	logic         kvs_room;
	logic         beat_ok;

	assign is_udp = stage2.data[ETH_TYPE_POS +: 16] == ETH_TYPE_IPV4 &&
		stage2.data[IP_PROTO_POS +: 8] == IP_PROTO_UDP;

	// Network byte order to host order
	assign sport  = {stage1.data[SPORT_POS +: 8], stage1.data[SPORT_POS + 8 +: 8]};
	assign dport  = {stage1.data[DPORT_POS +: 8], stage1.data[DPORT_POS + 8 +: 8]};
	assign magic  = stage1.data[MEMC_MAGIC_POS +: 8];
	assign opcode = memc_opcode_e'(stage1.data[MEMC_OPCODE_POS +: 8]);
	assign resvd  = stage1.data[MEMC_RESRVD_POS +: 16];
	assign totlen = {stage1.data[MEMC_TOTLEN_POS +: 8], stage1.data[MEMC_TOTLEN_POS + 8 +: 8],
		stage1.data[MEMC_TOTLEN_POS + 16 +: 8], stage1.data[MEMC_TOTLEN_POS + 24 +: 8]};
	assign short_len = totlen < MAX_DIVERT_LEN;

	always_comb begin
		hdr_route = ROUTE_NORMAL;
		if (is_udp && dport == kvs_port) begin
			if (magic == MAGIC_REQ && !short_len) begin
				hdr_route = ROUTE_NORMAL;
			end else if (div_en) begin
				if (magic == MAGIC_REQ && (opcode == OP_SET || opcode == OP_DELETE)) begin
					hdr_route = ROUTE_BOTH;
				end else if (!kvs_out_nearly_full) begin
					// No room downstream means the host serves it
					hdr_route = ROUTE_KVS;
				end
			end
		end else if (is_udp && sport == kvs_port) begin
			if (magic == MAGIC_RES && opcode == OP_GET && resvd == 16'h0 && short_len && div_en) begin
				hdr_route = ROUTE_BOTH;
			end
		end
	end

	// Header waits for its second beat
	assign hold = state == ST_HEADER && !stage2_empty && is_udp && stage1_empty;

	assign cur_route = (state == ST_HEADER) ? hdr_route : route;
	assign norm_room = !norm_full && !norm_nearly_full;
	assign kvs_room  = !kvs_nearly_full && !kvs_out_nearly_full;
	assign beat_ok   = !stage2_empty && !hold;

	// Both copies go in the same cycle or neither
	always_comb begin
		norm_wr = 1'b0;
		kvs_wr  = 1'b0;
		case (cur_route)
			ROUTE_KVS: kvs_wr = beat_ok && kvs_room;
			ROUTE_BOTH: begin
				norm_wr = beat_ok && norm_room && kvs_room;
				kvs_wr  = beat_ok && norm_room && kvs_room;
			end
			default: norm_wr = beat_ok && norm_room;
		endcase
	end

	always_ff @(posedge axis_aclk) begin
		if (!axis_resetn) begin
			state <= ST_HEADER;
			route <= ROUTE_NORMAL;
		end else if (norm_wr || kvs_wr) begin
			if (stage2.last) begin
				state <= ST_HEADER;
			end else if (state == ST_HEADER) begin
				state <= ST_PACKET;
				route <= hdr_route;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/div_stage_pipe.sv
// Two-stage beat pipeline; stage 2 is the current beat, stage 1 the look-ahead beat
`timescale 1ns/1ns
`default_nettype none

module div_stage_pipe import div_pkg::*; (
	input  logic       axis_aclk,
	input  logic       axis_resetn,
	input  axis_beat_t in_beat,
	input  logic       in_empty,
	input  logic       advance,
	output logic       rd_en,
	output axis_beat_t stage1,
	output axis_beat_t stage2,
	output logic       stage1_empty,
	output logic       stage2_empty
);

	logic load1;

	// Stage 1 also refills on its own while empty, so a held header can pick up beat two
	assign load1 = advance || stage1_empty;
	assign rd_en = load1 && !in_empty;

	// Payload
	always_ff @(posedge axis_aclk) begin
		if (advance) begin
			stage2 <= stage1;
		end
		if (load1) begin
			stage1 <= in_beat;
		end
	end

	// Occupancy
	always_ff @(posedge axis_aclk) begin
		if (!axis_resetn) begin
			stage1_empty <= 1'b1;
			stage2_empty <= 1'b1;
		end else begin
			if (advance) begin
				stage2_empty <= stage1_empty;
			end
			if (load1) begin
				stage1_empty <= in_empty;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/div_stream_fifo.sv
// Fall-through beat FIFO; writes to a full FIFO and reads from an empty one are ignored
`timescale 1ns/1ns
`default_nettype none

module div_stream_fifo import div_pkg::*; #(
	parameter int DEPTH_BITS = 4
) (
	input  logic       axis_aclk,
	input  logic       axis_resetn,
	input  axis_beat_t din,
	input  logic       wr_en,
	input  logic       rd_en,
	output axis_beat_t dout,
	output logic       full,
	output logic       nearly_full,
	output logic       empty
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	axis_beat_t mem [DEPTH];

	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head of queue always visible
	assign dout = mem[rd_ptr];

	assign full        = count == (DEPTH_BITS + 1)'(DEPTH);
	assign nearly_full = count >= (DEPTH_BITS + 1)'(DEPTH - 1);
	assign empty       = count == '0;

	always_ff @(posedge axis_aclk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!axis_resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/div_pkg.sv
// Beat layout, route and state encodings, memcached field offsets; packet bytes sit little-endian in data
`default_nettype none

package div_pkg;

	localparam int DATA_W = 256;
	localparam int USER_W = 128;
	localparam int KEEP_W = DATA_W / 8;

	// One stream beat, last in the top bit
	typedef struct packed {
		logic              last;
		logic [USER_W-1:0] user;
		logic [KEEP_W-1:0] keep;
		logic [DATA_W-1:0] data;
	} axis_beat_t;

	typedef enum logic [1:0] {
		ROUTE_NORMAL,
		ROUTE_KVS,
		ROUTE_BOTH
	} route_e;

	typedef enum logic {
		ST_HEADER,
		ST_PACKET
	} div_state_e;

	// Binary protocol commands
	typedef enum logic [7:0] {
		OP_GET    = 8'h00,
		OP_SET    = 8'h01,
		OP_DELETE = 8'h04
	} memc_opcode_e;

	typedef struct packed {
		logic [31:0] pkt_in;
		logic [31:0] norm_out;
		logic [31:0] kvs_out;
		logic [31:0] kvs_drop;
	} div_stats_t;

	// Header beat fields
	localparam int ETH_TYPE_POS = 96;
	localparam int IP_PROTO_POS = 184;

	// Byte-swapped as seen on the bus
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0008;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;

	// Second beat fields
	localparam int SPORT_POS       = 16;
	localparam int DPORT_POS       = 32;
	localparam int MEMC_MAGIC_POS  = 80;
	localparam int MEMC_OPCODE_POS = 88;
	localparam int MEMC_RESRVD_POS = 128;
	localparam int MEMC_TOTLEN_POS = 144;

	localparam logic [7:0] MAGIC_REQ = 8'h80;
	localparam logic [7:0] MAGIC_RES = 8'h81;

	// Requests this long or longer stay on the host path
	localparam int unsigned MAX_DIVERT_LEN = 512;

endpackage

`default_nettype wire
